//--- bench/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

function automatic logic [31:0] model_alu(input rv32i_types_pkg::exec_op_t op,
                                          input logic [31:0] a,
                                          input logic [31:0] b);
    logic [63:0] ext;
    logic [4:0]  sh;
    sh  = b[4:0];
    ext = {{32{a[31]}}, a} >> sh; // Sign bits shift in from the upper half
    case (op)
        rv32i_types_pkg::OP_ADD:  return a + b;
        rv32i_types_pkg::OP_SUB:  return a - b;
        rv32i_types_pkg::OP_SLL:  return a << sh;
        rv32i_types_pkg::OP_SLT:  return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
        rv32i_types_pkg::OP_SLTU: return {31'b0, a < b};
        rv32i_types_pkg::OP_XOR:  return a ^ b;
        rv32i_types_pkg::OP_SRL:  return a >> sh;
        rv32i_types_pkg::OP_SRA:  return ext[31:0];
        rv32i_types_pkg::OP_OR:   return a | b;
        rv32i_types_pkg::OP_AND:  return a & b;
        default:                  return '0;
    endcase
endfunction

function automatic logic [31:0] model_mul(input rv32i_types_pkg::exec_op_t op,
                                          input logic [31:0] a,
                                          input logic [31:0] b);
    logic [63:0] sa, sb, ua, ub, p;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'b0, a};
    ub = {32'b0, b};
    // Products taken modulo 2^64
    case (op)
        rv32i_types_pkg::OP_MULH:   p = sa * sb;
        rv32i_types_pkg::OP_MULHSU: p = sa * ub;
        default:                    p = ua * ub;
    endcase
    return (op == rv32i_types_pkg::OP_MUL) ? p[31:0] : p[63:32];
endfunction

function automatic logic [31:0] model_div(input rv32i_types_pkg::exec_op_t op,
                                          input logic [31:0] a,
                                          input logic [31:0] b);
    logic        signed_op;
    logic        neg_a, neg_b;
    logic [31:0] ma, mb, q, r;
    signed_op = (op == rv32i_types_pkg::OP_DIV) || (op == rv32i_types_pkg::OP_REM);
    if (b == 32'd0) begin
        q = '1;
        r = a;
    end else begin
        neg_a = signed_op && a[31];
        neg_b = signed_op && b[31];
        ma = neg_a ? -a : a;
        mb = neg_b ? -b : b;
        q = ma / mb;
        r = ma % mb;
        if (neg_a != neg_b) q = -q;
        if (neg_a) r = -r; // Remainder takes the dividend's sign
    end
    if ((op == rv32i_types_pkg::OP_DIV) || (op == rv32i_types_pkg::OP_DIVU)) begin
        return q;
    end
    return r;
endfunction

function automatic logic model_taken(input rv32i_types_pkg::issue_pkt_t p);
    logic lt_s, lt_u;
    lt_s = (p.rs1_v ^ 32'h8000_0000) < (p.rs2_v ^ 32'h8000_0000);
    lt_u = p.rs1_v < p.rs2_v;
    if (p.fu != rv32i_types_pkg::FU_BR) return 1'b0;
    case (p.decode.op)
        rv32i_types_pkg::OP_BEQ:  return p.rs1_v == p.rs2_v;
        rv32i_types_pkg::OP_BNE:  return p.rs1_v != p.rs2_v;
        rv32i_types_pkg::OP_BLT:  return lt_s;
        rv32i_types_pkg::OP_BGE:  return !lt_s;
        rv32i_types_pkg::OP_BLTU: return lt_u;
        rv32i_types_pkg::OP_BGEU: return !lt_u;
        rv32i_types_pkg::OP_JAL:  return 1'b1;
        rv32i_types_pkg::OP_JALR: return 1'b1;
        default:                  return 1'b0;
    endcase
endfunction

function automatic logic [31:0] model_target(input rv32i_types_pkg::issue_pkt_t p);
    logic [31:0] sum;
    sum = p.rs1_v + p.decode.imm;
    if (p.fu != rv32i_types_pkg::FU_BR) return '0;
    if (p.decode.op == rv32i_types_pkg::OP_JALR) return {sum[31:1], 1'b0};
    return p.decode.pc + p.decode.imm;
endfunction

function automatic logic [31:0] model_result(input rv32i_types_pkg::issue_pkt_t p);
    logic [31:0] b;
    b = p.decode.use_imm ? p.decode.imm : p.rs2_v;
    case (p.fu)
        rv32i_types_pkg::FU_ADD: return model_alu(p.decode.op, p.rs1_v, b);
        rv32i_types_pkg::FU_MUL: return model_mul(p.decode.op, p.rs1_v, p.rs2_v);
        rv32i_types_pkg::FU_DIV: return model_div(p.decode.op, p.rs1_v, p.rs2_v);
        default: begin
            if ((p.decode.op == rv32i_types_pkg::OP_JAL) ||
                (p.decode.op == rv32i_types_pkg::OP_JALR)) begin
                return p.decode.pc + 32'd4;
            end
            return '0;
        end
    endcase
endfunction

`endif

//--- bench/exec_tb.sv
`timescale 1ns/10ps

module exec_tb;

    localparam int ROB_SLOTS   = 2 ** exec_cfg_pkg::ROB_IDX_BITS;
    localparam int NUM_PKTS    = 400;
    localparam int RUN_LIMIT   = 6000;
    localparam int DRAIN_LIMIT = 20;

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        flush;
    logic                        issue_valid;
    rv32i_types_pkg::issue_pkt_t issue_pkt;
    logic                        issue_ready;
    rv32i_types_pkg::cdb_t       cdb_add, cdb_mul, cdb_div, cdb_br;

    // Scoreboard indexed by rob_idx
    logic                        live [ROB_SLOTS];
    rv32i_types_pkg::issue_pkt_t held [ROB_SLOTS];
    int                          due [ROB_SLOTS];
    logic [31:0]                 exp_rd [ROB_SLOTS];

    int                                    cycle;
    int                                    accepted;
    logic                                  took;
    logic [exec_cfg_pkg::ROB_IDX_BITS-1:0] next_rob;

    `include "exec_model.svh"

    always #50 clk = ~clk;

    exec_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .issue_valid(issue_valid),
        .issue_pkt  (issue_pkt),
        .issue_ready(issue_ready),
        .cdb_add    (cdb_add),
        .cdb_mul    (cdb_mul),
        .cdb_div    (cdb_div),
        .cdb_br     (cdb_br)
    );

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at cycle %0d", cycle);
    endtask

    task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] got);
        if (exp !== got) begin
            stop_with_error($sformatf("Mismatch %s exp=%0h got=%0h", name, exp, got));
        end
    endtask

    function automatic int live_count();
        int n;
        n = 0;
        for (int i = 0; i < ROB_SLOTS; i++) begin
            if (live[i]) n++;
        end
        return n;
    endfunction

    function automatic rv32i_types_pkg::issue_pkt_t random_packet(
        input logic [exec_cfg_pkg::ROB_IDX_BITS-1:0] rob
    );
        rv32i_types_pkg::issue_pkt_t p;
        logic [31:0]                 r;
        int                          op_n;
        p = '0;
        p.fu = rv32i_types_pkg::fu_type_t'(2'($urandom_range(3)));
        case (p.fu)
            rv32i_types_pkg::FU_ADD: op_n = int'(rv32i_types_pkg::OP_ADD) + $urandom_range(9);
            rv32i_types_pkg::FU_MUL: op_n = int'(rv32i_types_pkg::OP_MUL) + $urandom_range(3);
            rv32i_types_pkg::FU_DIV: op_n = int'(rv32i_types_pkg::OP_DIV) + $urandom_range(3);
            default:                 op_n = int'(rv32i_types_pkg::OP_BEQ) + $urandom_range(7);
        endcase
        p.decode.op = rv32i_types_pkg::exec_op_t'(5'(op_n));
        r = $urandom;
        p.rob_idx = rob;
        p.pd_s = r[5:0];
        p.rd_s = r[10:6];
        p.rs1_v = $urandom;
        p.rs2_v = $urandom;
        case (r[15:13])
            3'd0: p.rs2_v = '0; // Divide by zero
            3'd1: begin
                p.rs1_v = 32'h8000_0000;
                p.rs2_v = '1;
            end
            3'd2: p.rs2_v = p.rs1_v;
            3'd3: p.rs2_v = {27'b0, r[20:16]}; // Small divisor or shift
            default: ;
        endcase
        p.decode.inst = $urandom;
        r = $urandom;
        p.decode.pc = {r[31:2], 2'b00};
        p.decode.use_imm = r[0];
        r = $urandom;
        p.decode.imm = {{20{r[11]}}, r[11:0]};
        return p;
    endfunction

    task automatic check_bus(input rv32i_types_pkg::cdb_t c,
                             input rv32i_types_pkg::fu_type_t fu,
                             input string name);
        int idx;
        if (!c.valid) begin
            check_equal({name, " idle fields"}, 64'(0), 64'(|c));
        end else begin
            idx = int'(c.rob_idx);
            if (!live[idx]) begin
                stop_with_error($sformatf("%s broadcast rob_idx %0d with no packet in flight",
                                          name, idx));
            end
            if (held[idx].fu != fu) begin
                stop_with_error($sformatf("%s carried rob_idx %0d of another unit class",
                                          name, idx));
            end
            check_equal({name, " result cycle"}, 64'(due[idx]), 64'(cycle));
            check_equal({name, ".pd_s"}, 64'(held[idx].pd_s), 64'(c.pd_s));
            check_equal({name, ".rd_s"}, 64'(held[idx].rd_s), 64'(c.rd_s));
            check_equal({name, ".inst"}, 64'(held[idx].decode.inst), 64'(c.inst));
            check_equal({name, ".rd_v"}, 64'(exp_rd[idx]), 64'(c.rd_v));
            check_equal({name, ".pc_select"}, 64'(model_taken(held[idx])), 64'(c.pc_select));
            check_equal({name, ".pc_branch"}, 64'(model_target(held[idx])), 64'(c.pc_branch));
            live[idx] = 1'b0;
        end
    endtask

    // Runs mid-cycle, where DUT outputs are settled
    task automatic sample_cycle();
        int idx;
        int lat;
        if (flush) begin
            check_equal("cdb valid under flush", 64'(0),
                        64'({cdb_add.valid, cdb_mul.valid, cdb_div.valid, cdb_br.valid}));
            for (int i = 0; i < ROB_SLOTS; i++) begin
                live[i] = 1'b0;
            end
        end else begin
            check_bus(cdb_add, rv32i_types_pkg::FU_ADD, "cdb_add");
            check_bus(cdb_mul, rv32i_types_pkg::FU_MUL, "cdb_mul");
            check_bus(cdb_div, rv32i_types_pkg::FU_DIV, "cdb_div");
            check_bus(cdb_br, rv32i_types_pkg::FU_BR, "cdb_br");
        end
        for (int i = 0; i < ROB_SLOTS; i++) begin
            if (live[i] && cycle >= due[i]) begin
                stop_with_error($sformatf("No result for rob_idx %0d by cycle %0d", i, due[i]));
            end
        end
        took = issue_valid && issue_ready;
        if (took) begin
            idx = int'(issue_pkt.rob_idx);
            if (live[idx]) begin
                stop_with_error($sformatf("rob_idx %0d accepted again while in flight", idx));
            end
            case (issue_pkt.fu)
                rv32i_types_pkg::FU_MUL: lat = exec_cfg_pkg::MUL_LATENCY;
                rv32i_types_pkg::FU_DIV: lat = exec_cfg_pkg::DIV_LATENCY;
                default:                 lat = 0;
            endcase
            live[idx]   = 1'b1;
            held[idx]   = issue_pkt;
            due[idx]    = cycle + 1 + lat;
            exp_rd[idx] = model_result(issue_pkt);
            accepted++;
        end
    endtask

    initial begin
        int waited;
        void'($urandom(3309));
        rst         = 1'b1;
        flush       = 1'b0;
        issue_valid = 1'b0;
        issue_pkt   = '0;
        cycle       = 0;
        accepted    = 0;
        took        = 1'b0;
        next_rob    = '0;
        for (int i = 0; i < ROB_SLOTS; i++) begin
            live[i] = 1'b0;
        end

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_equal("issue_ready", 64'(1), 64'(issue_ready));
        sample_cycle(); // Nothing in flight, so any valid CDB fails

        waited = 0;
        while (accepted < NUM_PKTS) begin
            @(posedge clk);
            cycle++;
            waited++;
            if (waited > RUN_LIMIT) begin
                stop_with_error("Issue phase did not finish within the cycle limit");
            end
            // Packet stays unchanged at the source until accepted
            if (!issue_valid || took) begin
                if ($urandom_range(7) == 0) begin
                    issue_valid <= 1'b0;
                end else begin
                    issue_pkt   <= random_packet(next_rob);
                    issue_valid <= 1'b1;
                    next_rob = next_rob + 1'b1;
                end
            end
            flush <= ($urandom_range(39) == 0);
            @(negedge clk);
            sample_cycle();
        end

        waited = 0;
        while (live_count() != 0) begin
            @(posedge clk);
            cycle++;
            waited++;
            if (waited > DRAIN_LIMIT) begin
                stop_with_error("Results in flight did not arrive after issue stopped");
            end
            issue_valid <= 1'b0;
            flush       <= 1'b0;
            @(negedge clk);
            sample_cycle();
        end

        // Late results of squashed multiplies or divides would land here
        repeat (exec_cfg_pkg::MUL_LATENCY + exec_cfg_pkg::DIV_LATENCY) begin
            @(posedge clk);
            cycle++;
            @(negedge clk);
            sample_cycle();
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- rtl/exec_cfg_pkg.sv
package exec_cfg_pkg;

    // Tag widths
    localparam int ROB_IDX_BITS  = 6;
    localparam int PHYS_REG_BITS = 6;
    localparam int ARCH_REG_BITS = 5;

    // Hold cycles after start
    localparam int MUL_LATENCY = 4;
    localparam int DIV_LATENCY = 4;

    localparam int HOLD_CNT_BITS = 3; // Wide enough for either latency
    typedef logic [HOLD_CNT_BITS-1:0] hold_cnt_t;

endpackage

//--- rtl/exec_top.sv
`timescale 1ns/10ps

module exec_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        issue_valid,
    input  rv32i_types_pkg::issue_pkt_t issue_pkt,
    output logic                        issue_ready,
    output rv32i_types_pkg::cdb_t       cdb_add,
    output rv32i_types_pkg::cdb_t       cdb_mul,
    output rv32i_types_pkg::cdb_t       cdb_div,
    output rv32i_types_pkg::cdb_t       cdb_br
);

    rv32i_types_pkg::issue_pkt_t req;
    logic start_add, start_mul, start_div, start_br;
    logic busy_mul, busy_div;

    issue_stage issue_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .issue_valid(issue_valid),
        .issue_pkt  (issue_pkt),
        .issue_ready(issue_ready),
        .busy_mul   (busy_mul),
        .busy_div   (busy_div),
        .req        (req),
        .start_add  (start_add),
        .start_mul  (start_mul),
        .start_div  (start_div),
        .start_br   (start_br)
    );

    execute execute_i (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .req      (req),
        .start_add(start_add),
        .start_mul(start_mul),
        .start_div(start_div),
        .start_br (start_br),
        .busy_mul (busy_mul),
        .busy_div (busy_div),
        .cdb_add  (cdb_add),
        .cdb_mul  (cdb_mul),
        .cdb_div  (cdb_div),
        .cdb_br   (cdb_br)
    );

endmodule

//--- rtl/execute.sv
`timescale 1ns/10ps

module execute (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  rv32i_types_pkg::issue_pkt_t req,
    input  logic                        start_add,
    input  logic                        start_mul,
    input  logic                        start_div,
    input  logic                        start_br,
    output logic                        busy_mul,
    output logic                        busy_div,
    output rv32i_types_pkg::cdb_t       cdb_add,
    output rv32i_types_pkg::cdb_t       cdb_mul,
    output rv32i_types_pkg::cdb_t       cdb_div,
    output rv32i_types_pkg::cdb_t       cdb_br
);

    typedef struct packed {
        logic [exec_cfg_pkg::ROB_IDX_BITS-1:0]  rob_idx;
        logic [exec_cfg_pkg::PHYS_REG_BITS-1:0] pd_s;
        logic [exec_cfg_pkg::ARCH_REG_BITS-1:0] rd_s;
        logic [31:0]                             inst;
    } tag_t;

    tag_t req_tag;
    tag_t mul_tag;
    tag_t div_tag;

    logic [exec_cfg_pkg::MUL_LATENCY-1:0] mul_chain;
    logic [exec_cfg_pkg::DIV_LATENCY-1:0] div_chain;

    logic [31:0] rd_v_add, rd_v_mul, rd_v_div, rd_v_br;
    logic        valid_add, valid_mul, valid_div, valid_br;
    logic        pc_select;
    logic [31:0] pc_branch;

    function automatic rv32i_types_pkg::cdb_t make_cdb(
        input logic        v,
        input tag_t        tag,
        input logic [31:0] value,
        input logic        taken,
        input logic [31:0] target
    );
        rv32i_types_pkg::cdb_t c;
        c = '0;
        if (v) begin
            c.rob_idx   = tag.rob_idx;
            c.pd_s      = tag.pd_s;
            c.rd_s      = tag.rd_s;
            c.rd_v      = value;
            c.valid     = 1'b1;
            c.inst      = tag.inst;
            c.pc_select = taken;
            c.pc_branch = target;
        end
        return c;
    endfunction

    assign req_tag = '{rob_idx: req.rob_idx, pd_s: req.pd_s, rd_s: req.rd_s,
                       inst: req.decode.inst};

    // Tags of multi-cycle ops, held until their result
    always_ff @(posedge clk) begin
        if (start_mul) mul_tag <= req_tag;
        if (start_div) div_tag <= req_tag;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            mul_chain <= '0;
            div_chain <= '0;
        end else begin
            mul_chain <= {mul_chain[exec_cfg_pkg::MUL_LATENCY-2:0], start_mul};
            div_chain <= {div_chain[exec_cfg_pkg::DIV_LATENCY-2:0], start_div};
        end
    end

    assign busy_mul = |mul_chain;
    assign busy_div = |div_chain;

    fu_add fu_add_i (
        .rs1_v      (req.rs1_v),
        .rs2_v      (req.rs2_v),
        .decode_info(req.decode),
        .start      (start_add),
        .rd_v       (rd_v_add),
        .valid      (valid_add)
    );

    fu_mult fu_mult_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .start      (start_mul),
        .rs1_v      (req.rs1_v),
        .rs2_v      (req.rs2_v),
        .decode_info(req.decode),
        .hold       (busy_mul),
        .rd_v       (rd_v_mul),
        .valid      (valid_mul)
    );

    fu_div_rem fu_div_i (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .start      (start_div),
        .rs1_v      (req.rs1_v),
        .rs2_v      (req.rs2_v),
        .decode_info(req.decode),
        .hold       (busy_div),
        .rd_v       (rd_v_div),
        .valid      (valid_div)
    );

    fu_br fu_br_i (
        .rs1_v      (req.rs1_v),
        .rs2_v      (req.rs2_v),
        .decode_info(req.decode),
        .start      (start_br),
        .rd_v       (rd_v_br),
        .valid      (valid_br),
        .pc_select  (pc_select),
        .pc_branch  (pc_branch)
    );

    always_comb begin
        cdb_add = make_cdb(valid_add && !flush, req_tag, rd_v_add, 1'b0, '0);
        cdb_mul = make_cdb(valid_mul && !flush, mul_tag, rd_v_mul, 1'b0, '0);
        cdb_div = make_cdb(valid_div && !flush, div_tag, rd_v_div, 1'b0, '0);
        cdb_br  = make_cdb(valid_br && !flush, req_tag, rd_v_br, pc_select, pc_branch);
    end

endmodule

//--- rtl/fu_add.sv
`timescale 1ns/10ps

module fu_add (
    input  logic [31:0]                   rs1_v,
    input  logic [31:0]                   rs2_v,
    input  rv32i_types_pkg::decode_info_t decode_info,
    input  logic                          start,
    output logic [31:0]                   rd_v,
    output logic                          valid
);

    logic [31:0] op_b;

    always_comb begin
        op_b = decode_info.use_imm ? decode_info.imm : rs2_v;
        case (decode_info.op)
            rv32i_types_pkg::OP_ADD:  rd_v = rs1_v + op_b;
            rv32i_types_pkg::OP_SUB:  rd_v = rs1_v - op_b;
            rv32i_types_pkg::OP_SLL:  rd_v = rs1_v << op_b[4:0];
            rv32i_types_pkg::OP_SLT:  rd_v = {31'b0, $signed(rs1_v) < $signed(op_b)};
            rv32i_types_pkg::OP_SLTU: rd_v = {31'b0, rs1_v < op_b};
            rv32i_types_pkg::OP_XOR:  rd_v = rs1_v ^ op_b;
            rv32i_types_pkg::OP_SRL:  rd_v = rs1_v >> op_b[4:0];
            rv32i_types_pkg::OP_SRA:  rd_v = $signed(rs1_v) >>> op_b[4:0];
            rv32i_types_pkg::OP_OR:   rd_v = rs1_v | op_b;
            rv32i_types_pkg::OP_AND:  rd_v = rs1_v & op_b;
            default:                  rd_v = '0;
        endcase
        valid = start; // Single cycle
    end

endmodule

//--- rtl/fu_br.sv
`timescale 1ns/10ps

module fu_br (
    input  logic [31:0]                   rs1_v,
    input  logic [31:0]                   rs2_v,
    input  rv32i_types_pkg::decode_info_t decode_info,
    input  logic                          start,
    output logic [31:0]                   rd_v,
    output logic                          valid,
    output logic                          pc_select,
    output logic [31:0]                   pc_branch
);

    logic is_jump;
    logic is_jalr;

    always_comb begin
        is_jalr = (decode_info.op == rv32i_types_pkg::OP_JALR);
        is_jump = is_jalr || (decode_info.op == rv32i_types_pkg::OP_JAL);

        case (decode_info.op)
            rv32i_types_pkg::OP_BEQ:  pc_select = (rs1_v == rs2_v);
            rv32i_types_pkg::OP_BNE:  pc_select = (rs1_v != rs2_v);
            rv32i_types_pkg::OP_BLT:  pc_select = ($signed(rs1_v) < $signed(rs2_v));
            rv32i_types_pkg::OP_BGE:  pc_select = ($signed(rs1_v) >= $signed(rs2_v));
            rv32i_types_pkg::OP_BLTU: pc_select = (rs1_v < rs2_v);
            rv32i_types_pkg::OP_BGEU: pc_select = (rs1_v >= rs2_v);
            rv32i_types_pkg::OP_JAL,
            rv32i_types_pkg::OP_JALR: pc_select = 1'b1;
            default:                  pc_select = 1'b0;
        endcase

        if (is_jalr) begin
            pc_branch = (rs1_v + decode_info.imm) & ~32'd1;
        end else begin
            pc_branch = decode_info.pc + decode_info.imm;
        end

        rd_v  = is_jump ? decode_info.pc + 32'd4 : '0; // Link value
        valid = start;
    end

endmodule

//--- rtl/fu_div_rem.sv
`timescale 1ns/10ps

module fu_div_rem (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          start,
    input  logic [31:0]                   rs1_v,
    input  logic [31:0]                   rs2_v,
    input  rv32i_types_pkg::decode_info_t decode_info,
    input  logic                          hold,
    output logic [31:0]                   rd_v,
    output logic                          valid
);

    logic [31:0]               a_q, b_q;
    rv32i_types_pkg::exec_op_t op_q;
    logic                      pending;
    exec_cfg_pkg::hold_cnt_t   hold_cnt;
    logic                      is_signed;
    logic                      div_zero;
    logic                      div_ovf;
    logic [31:0]               quo, rem;

    always_ff @(posedge clk) begin
        if (start) begin
            a_q  <= rs1_v;
            b_q  <= rs2_v;
            op_q <= decode_info.op;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            pending  <= 1'b0;
            hold_cnt <= '0;
        end else if (start) begin
            pending  <= 1'b1;
            hold_cnt <= '0;
        end else if (valid) begin
            pending <= 1'b0;
        end else if (hold) begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    always_comb begin
        is_signed = (op_q == rv32i_types_pkg::OP_DIV) || (op_q == rv32i_types_pkg::OP_REM);
        div_zero  = (b_q == '0);
        div_ovf   = is_signed && (a_q == 32'h8000_0000) && (b_q == '1);

        if (div_zero) begin
            quo = '1;
            rem = a_q;
        end else if (div_ovf) begin
            quo = a_q; // -2^31 / -1 wraps
            rem = '0;
        end else if (is_signed) begin
            quo = $signed(a_q) / $signed(b_q);
            rem = $signed(a_q) % $signed(b_q);
        end else begin
            quo = a_q / b_q;
            rem = a_q % b_q;
        end

        if ((op_q == rv32i_types_pkg::OP_DIV) || (op_q == rv32i_types_pkg::OP_DIVU)) begin
            rd_v = quo;
        end else begin
            rd_v = rem;
        end
        valid = pending && hold &&
                (hold_cnt == exec_cfg_pkg::hold_cnt_t'(exec_cfg_pkg::DIV_LATENCY - 1));
    end

endmodule

//--- rtl/fu_mult.sv
`timescale 1ns/10ps

module fu_mult (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  logic                          start,
    input  logic [31:0]                   rs1_v,
    input  logic [31:0]                   rs2_v,
    input  rv32i_types_pkg::decode_info_t decode_info,
    input  logic                          hold,
    output logic [31:0]                   rd_v,
    output logic                          valid
);

    logic [31:0]               a_q, b_q;
    rv32i_types_pkg::exec_op_t op_q;
    logic                      pending;
    exec_cfg_pkg::hold_cnt_t   hold_cnt;
    logic signed [32:0]        a_ext, b_ext;
    logic signed [65:0]        prod;

    always_ff @(posedge clk) begin
        if (start) begin
            a_q  <= rs1_v;
            b_q  <= rs2_v;
            op_q <= decode_info.op;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            pending  <= 1'b0;
            hold_cnt <= '0;
        end else if (start) begin
            pending  <= 1'b1;
            hold_cnt <= '0;
        end else if (valid) begin
            pending <= 1'b0;
        end else if (hold) begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    always_comb begin
        // rs1 unsigned only for MULHU, rs2 signed only for MULH
        a_ext = {(op_q != rv32i_types_pkg::OP_MULHU) && a_q[31], a_q};
        b_ext = {(op_q == rv32i_types_pkg::OP_MULH) && b_q[31], b_q};
        prod  = a_ext * b_ext;
        rd_v  = (op_q == rv32i_types_pkg::OP_MUL) ? prod[31:0] : prod[63:32];
        valid = pending && hold &&
                (hold_cnt == exec_cfg_pkg::hold_cnt_t'(exec_cfg_pkg::MUL_LATENCY - 1));
    end

endmodule

//--- rtl/issue_stage.sv
`timescale 1ns/10ps

module issue_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        issue_valid,
    input  rv32i_types_pkg::issue_pkt_t issue_pkt,
    output logic                        issue_ready,
    input  logic                        busy_mul,
    input  logic                        busy_div,
    output rv32i_types_pkg::issue_pkt_t req,
    output logic                        start_add,
    output logic                        start_mul,
    output logic                        start_div,
    output logic                        start_br
);

    logic occupied;
    logic fire;
    logic unit_busy;

    always_comb begin
        fire = occupied && !flush; // Squashed packet never starts
        start_add = fire && (req.fu == rv32i_types_pkg::FU_ADD);
        start_mul = fire && (req.fu == rv32i_types_pkg::FU_MUL);
        start_div = fire && (req.fu == rv32i_types_pkg::FU_DIV);
        start_br  = fire && (req.fu == rv32i_types_pkg::FU_BR);

        // A unit starting now is busy for the next packet of its class
        case (issue_pkt.fu)
            rv32i_types_pkg::FU_MUL: unit_busy = busy_mul || start_mul;
            rv32i_types_pkg::FU_DIV: unit_busy = busy_div || start_div;
            default:                 unit_busy = 1'b0;
        endcase

        issue_ready = (!occupied || fire) && !flush && !unit_busy;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            occupied <= 1'b0;
        end else begin
            occupied <= issue_valid && issue_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_ready) begin
            req <= issue_pkt;
        end
    end

endmodule

//--- rtl/rv32i_types_pkg.sv
package rv32i_types_pkg;

    typedef enum logic [1:0] {
        FU_ADD,
        FU_MUL,
        FU_DIV,
        FU_BR
    } fu_type_t;

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
        OP_DIV, OP_DIVU, OP_REM, OP_REMU,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR
    } exec_op_t;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] imm;
        exec_op_t    op;
        logic        use_imm; // ALU second operand is imm
    } decode_info_t;

    typedef struct packed {
        fu_type_t                                fu;
        logic [exec_cfg_pkg::ROB_IDX_BITS-1:0]  rob_idx;
        logic [exec_cfg_pkg::PHYS_REG_BITS-1:0] pd_s;
        logic [exec_cfg_pkg::ARCH_REG_BITS-1:0] rd_s;
        logic [31:0]                             rs1_v;
        logic [31:0]                             rs2_v;
        decode_info_t                            decode;
    } issue_pkt_t;

    typedef struct packed {
        logic [exec_cfg_pkg::ROB_IDX_BITS-1:0]  rob_idx;
        logic [exec_cfg_pkg::PHYS_REG_BITS-1:0] pd_s;
        logic [exec_cfg_pkg::ARCH_REG_BITS-1:0] rd_s;
        logic [31:0]                             rd_v;
        logic                                    valid;
        logic [31:0]                             inst;
        logic                                    pc_select; // Branch taken
        logic [31:0]                             pc_branch;
    } cdb_t;

endpackage

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module exec_tb -f verilog.f -Mdir obj_dir -o exec_sim
./obj_dir/exec_sim

//--- verilog.f
+incdir+bench
rtl/exec_cfg_pkg.sv
rtl/rv32i_types_pkg.sv
rtl/fu_add.sv
rtl/fu_mult.sv
rtl/fu_div_rem.sv
rtl/fu_br.sv
rtl/issue_stage.sv
rtl/execute.sv
rtl/exec_top.sv
bench/exec_tb.sv
